// ==== core_cfg.svh ====
// Core configuration
// Data width, register count, boot default and CSR numbers of the RV32 core

`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

////////////////////////////////////////
// Data path
////////////////////////////////////////

`define CORE_XLEN      32
`define CORE_NUM_REGS  32

// Reset fetch address of the platform
`define CORE_BOOT_ADDR 32'h0000_0080

////////////////////////////////////////
// CSR numbers
////////////////////////////////////////

`define CORE_CSR_MSCRATCH 12'h340
`define CORE_CSR_MINSTRET 12'hB02

// Custom event counters next to minstret
`define CORE_CSR_MLOADS   12'hB03
`define CORE_CSR_MSTORES  12'hB04

`endif

// ==== core_pkg.sv ====
// Core types
// Data and index vectors, FSM and ALU encodings, and the packed structs
// that carry the memory buses and the controller commands

`include "core_cfg.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0]             word_t;
  typedef logic [`CORE_XLEN-1:0]             addr_t;
  typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_addr_t;
  typedef logic [11:0]                       csr_addr_t;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    IDLE,
    DECODE,
    WAIT_LSU
  } ctrl_state_e;

  typedef enum logic {
    CSR_WRITE = 1'b0,
    CSR_SET   = 1'b1
  } csr_op_e;

  ////////////////////////////////////////
  // Memory bus, shared by both ports
  ////////////////////////////////////////

  typedef struct packed {
    logic       req;
    logic       we;
    logic [3:0] be;
    addr_t      addr;
    word_t      wdata;
  } mem_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    word_t rdata;
  } mem_rsp_t;

  // Controller commands
  typedef struct packed {
    logic  valid;
    logic  we;
    addr_t addr;
    word_t wdata;
  } lsu_cmd_t;

  typedef struct packed {
    logic      access;
    csr_op_e   op;
    csr_addr_t addr;
    word_t     wdata;
  } csr_cmd_t;

endpackage

// ==== core_if_stage.sv ====
// Instruction fetch stage
// Sequential fetch from the boot address over the instruction bus, with a
// one-entry buffer that holds the word and PC offered to the controller

module core_if_stage
  import core_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     fetch_enable_i,
  input  addr_t    boot_addr_i,
  output mem_req_t instr_req_o,
  input  mem_rsp_t instr_rsp_i,
  output logic     instr_valid_o,
  output word_t    instr_rdata_o,
  output addr_t    instr_pc_o,
  input  logic     instr_taken_i,
  output logic     busy_o
);

  logic  enable_q;
  addr_t pc_q;
  logic  outstanding_q;
  addr_t rsp_pc_q;
  logic  buf_valid_q;
  word_t buf_instr_q;
  addr_t buf_pc_q;
  logic  fetch_req;
  logic  fetch_gnt;
  logic  fetch_rvalid;

  // Only ask when the reply is sure to find an empty buffer
  assign fetch_req    = enable_q & ~outstanding_q & (~buf_valid_q | instr_taken_i);
  assign fetch_gnt    = fetch_req & instr_rsp_i.gnt;
  assign fetch_rvalid = outstanding_q & instr_rsp_i.rvalid;

  assign instr_req_o.req   = fetch_req;
  assign instr_req_o.we    = 1'b0;
  assign instr_req_o.be    = 4'hF;
  assign instr_req_o.addr  = pc_q;
  assign instr_req_o.wdata = '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enable_q      <= 1'b0;
      pc_q          <= '0;
      outstanding_q <= 1'b0;
      buf_valid_q   <= 1'b0;
    end else begin
      // First enable loads the boot address
      if (!enable_q && fetch_enable_i) begin
        enable_q <= 1'b1;
        pc_q     <= boot_addr_i;
      end
      if (fetch_gnt) begin
        outstanding_q <= 1'b1;
        pc_q          <= pc_q + addr_t'(4);
      end else if (fetch_rvalid) begin
        outstanding_q <= 1'b0;
      end
      if (fetch_rvalid) begin
        buf_valid_q <= 1'b1;
      end else if (instr_taken_i) begin
        buf_valid_q <= 1'b0;
      end
    end
  end

  // Fetched word and its PC
  always_ff @(posedge clk_i) begin
    if (fetch_gnt) begin
      rsp_pc_q <= pc_q;
    end
    if (fetch_rvalid) begin
      buf_instr_q <= instr_rsp_i.rdata;
      buf_pc_q    <= rsp_pc_q;
    end
  end

  assign instr_valid_o = buf_valid_q;
  assign instr_rdata_o = buf_instr_q;
  assign instr_pc_o    = buf_pc_q;

  // Busy from the enable edge until the reply lands in the buffer
  assign busy_o = (fetch_enable_i & ~enable_q) | fetch_req | outstanding_q;

  // Address phase is held until the memory grants it
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o.req && !instr_rsp_i.gnt |=> instr_req_o.req && $stable(instr_req_o.addr));

endmodule

// ==== core_id_ex_stage.sv ====
// Decode and execute stage
// Decodes one instruction at a time, reads and writes the register file,
// runs the ALU and hands loads, stores and CSR accesses to their units

module core_id_ex_stage
  import core_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     instr_valid_i,
  input  word_t    instr_rdata_i,
  output logic     instr_taken_o,
  output lsu_cmd_t lsu_cmd_o,
  input  logic     lsu_done_i,
  input  word_t    lsu_rdata_i,
  output csr_cmd_t csr_cmd_o,
  input  word_t    csr_rdata_i,
  output logic     instr_retired_o,
  output logic     busy_o
);

  localparam logic [6:0] OPC_LOAD   = 7'h03;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_STORE  = 7'h23;
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_LUI    = 7'h37;
  localparam logic [6:0] OPC_SYSTEM = 7'h73;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  word_t       rf_q [2**$bits(reg_addr_t)];

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  reg_addr_t   rd;
  reg_addr_t   rs1;
  reg_addr_t   rs2;
  word_t       imm_i;
  word_t       imm_s;
  word_t       imm_u;
  word_t       rs1_val;
  word_t       rs2_val;
  logic        is_addi;
  logic        is_rtype;
  logic        is_lui;
  logic        is_load;
  logic        is_store;
  logic        is_csr;
  logic        is_mem;
  logic        writes_rd;
  alu_op_e     alu_op;
  word_t       alu_b;
  word_t       alu_result;
  logic        retire;
  logic        rf_we;
  word_t       rf_wdata;

  ////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////

  assign opcode = instr_rdata_i[6:0];
  assign rd     = instr_rdata_i[11:7];
  assign funct3 = instr_rdata_i[14:12];
  assign rs1    = instr_rdata_i[19:15];
  assign rs2    = instr_rdata_i[24:20];
  assign funct7 = instr_rdata_i[31:25];

  assign imm_i = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:20]};
  assign imm_s = {{20{instr_rdata_i[31]}}, instr_rdata_i[31:25], instr_rdata_i[11:7]};
  assign imm_u = {instr_rdata_i[31:12], 12'b0};

  assign is_addi  = (opcode == OPC_OP_IMM) && (funct3 == 3'b000);
  assign is_lui   = (opcode == OPC_LUI);
  assign is_load  = (opcode == OPC_LOAD) && (funct3 == 3'b010);
  assign is_store = (opcode == OPC_STORE) && (funct3 == 3'b010);
  assign is_csr   = (opcode == OPC_SYSTEM) && (funct3 == 3'b001 || funct3 == 3'b010);
  // ADD/SUB, XOR, OR, AND
  assign is_rtype = (opcode == OPC_OP) &&
                    (((funct3 == 3'b000) && (funct7 == 7'h00 || funct7 == 7'h20)) ||
                     ((funct7 == 7'h00) && (funct3 == 3'b100 || funct3 == 3'b110 ||
                                            funct3 == 3'b111)));

  assign is_mem    = is_load | is_store;
  assign writes_rd = is_addi | is_rtype | is_lui | is_load | is_csr;

  // Register file reads with x0 tied to zero
  assign rs1_val = (rs1 == '0) ? '0 : rf_q[rs1];
  assign rs2_val = (rs2 == '0) ? '0 : rf_q[rs2];

  ////////////////////////////////////////
  // ALU that also forms load/store addresses
  ////////////////////////////////////////

  always_comb begin
    alu_op = ALU_ADD;
    alu_b  = imm_i;
    if (is_rtype) begin
      alu_b = rs2_val;
      case (funct3)
        3'b100:  alu_op = ALU_XOR;
        3'b110:  alu_op = ALU_OR;
        3'b111:  alu_op = ALU_AND;
        default: alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
      endcase
    end else if (is_lui) begin
      alu_op = ALU_PASS_B;
      alu_b  = imm_u;
    end else if (is_store) begin
      alu_b = imm_s;
    end
  end

  always_comb begin
    case (alu_op)
      ALU_SUB:    alu_result = rs1_val - alu_b;
      ALU_AND:    alu_result = rs1_val & alu_b;
      ALU_OR:     alu_result = rs1_val | alu_b;
      ALU_XOR:    alu_result = rs1_val ^ alu_b;
      ALU_PASS_B: alu_result = alu_b;
      default:    alu_result = rs1_val + alu_b;
    endcase
  end

  ////////////////////////////////////////
  // Controller FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (instr_valid_i) begin
          state_d = DECODE;
        end
      end
      DECODE:   state_d = is_mem ? WAIT_LSU : IDLE;
      WAIT_LSU: begin
        if (lsu_done_i) begin
          state_d = IDLE;
        end
      end
      default:  state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign retire = ((state_q == DECODE) && !is_mem) || ((state_q == WAIT_LSU) && lsu_done_i);

  assign instr_taken_o   = retire;
  assign instr_retired_o = retire;
  assign busy_o          = (state_q != IDLE) | instr_valid_i;

  assign lsu_cmd_o.valid = (state_q == DECODE) && is_mem;
  assign lsu_cmd_o.we    = is_store;
  assign lsu_cmd_o.addr  = alu_result;
  assign lsu_cmd_o.wdata = rs2_val;

  assign csr_cmd_o.access = (state_q == DECODE) && is_csr;
  assign csr_cmd_o.op     = funct3[1] ? CSR_SET : CSR_WRITE;
  assign csr_cmd_o.addr   = instr_rdata_i[31:20];
  assign csr_cmd_o.wdata  = rs1_val;

  // Writeback at retirement
  assign rf_we    = retire & writes_rd & (rd != '0);
  assign rf_wdata = is_load ? lsu_rdata_i : (is_csr ? csr_rdata_i : alu_result);

  always_ff @(posedge clk_i) begin
    if (rf_we) begin
      rf_q[rd] <= rf_wdata;
    end
  end

  // LSU completes only the access the FSM is waiting on
  a_done_in_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_done_i |-> state_q == WAIT_LSU);

endmodule

// ==== core_load_store_unit.sv ====
// Load/store unit
// Issues one word access on the data bus per command, holds the request
// until grant and reports completion with the load data on rvalid

module core_load_store_unit
  import core_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  lsu_cmd_t lsu_cmd_i,
  output mem_req_t data_req_o,
  input  mem_rsp_t data_rsp_i,
  output logic     lsu_done_o,
  output word_t    lsu_rdata_o,
  output logic     busy_o
);

  logic  pending_q;
  logic  waiting_q;
  logic  we_q;
  addr_t addr_q;
  word_t wdata_q;
  logic  granted;

  assign granted = pending_q & data_rsp_i.gnt;

  ////////////////////////////////////////
  // Transaction tracking
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      waiting_q <= 1'b0;
    end else begin
      if (lsu_cmd_i.valid) begin
        pending_q <= 1'b1;
      end else if (granted) begin
        pending_q <= 1'b0;
      end
      if (granted) begin
        waiting_q <= 1'b1;
      end else if (data_rsp_i.rvalid) begin
        waiting_q <= 1'b0;
      end
    end
  end

  // Request fields held stable from the command to the grant
  always_ff @(posedge clk_i) begin
    if (lsu_cmd_i.valid) begin
      we_q    <= lsu_cmd_i.we;
      addr_q  <= lsu_cmd_i.addr;
      wdata_q <= lsu_cmd_i.wdata;
    end
  end

  assign data_req_o.req   = pending_q;
  assign data_req_o.we    = we_q;
  assign data_req_o.be    = 4'hF;
  assign data_req_o.addr  = addr_q;
  assign data_req_o.wdata = wdata_q;

  // Stores also complete on rvalid
  assign lsu_done_o  = waiting_q & data_rsp_i.rvalid;
  assign lsu_rdata_o = data_rsp_i.rdata;
  assign busy_o      = pending_q | waiting_q;

  // Memory answers only granted accesses
  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_rsp_i.rvalid |-> waiting_q);

  // Controller waits for completion before the next command
  a_cmd_when_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_cmd_i.valid |-> !pending_q && !waiting_q);

endmodule

// ==== core_cs_registers.sv ====
// Control and status registers
// mscratch plus counters of retired instructions, granted loads and
// granted stores; reads are combinational from the CSR number

`include "core_cfg.svh"

module core_cs_registers
  import core_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  csr_cmd_t csr_cmd_i,
  output word_t    csr_rdata_o,
  input  logic     instr_retired_i,
  input  mem_req_t data_req_i,
  input  mem_rsp_t data_rsp_i
);

  word_t mscratch_q;
  word_t minstret_q;
  word_t mloads_q;
  word_t mstores_q;
  logic  mscratch_we;
  logic  load_granted;
  logic  store_granted;

  // Counted at the address phase of the data bus
  assign load_granted  = data_req_i.req & data_rsp_i.gnt & ~data_req_i.we;
  assign store_granted = data_req_i.req & data_rsp_i.gnt & data_req_i.we;

  assign mscratch_we = csr_cmd_i.access && (csr_cmd_i.addr == `CORE_CSR_MSCRATCH);

  // Old values, so a read never sees its own retirement
  always_comb begin
    case (csr_cmd_i.addr)
      `CORE_CSR_MSCRATCH: csr_rdata_o = mscratch_q;
      `CORE_CSR_MINSTRET: csr_rdata_o = minstret_q;
      `CORE_CSR_MLOADS:   csr_rdata_o = mloads_q;
      `CORE_CSR_MSTORES:  csr_rdata_o = mstores_q;
      default:            csr_rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mscratch_q <= '0;
      minstret_q <= '0;
      mloads_q   <= '0;
      mstores_q  <= '0;
    end else begin
      // Counters are read-only
      if (mscratch_we) begin
        mscratch_q <= (csr_cmd_i.op == CSR_SET) ? (mscratch_q | csr_cmd_i.wdata)
                                                : csr_cmd_i.wdata;
      end
      if (instr_retired_i) begin
        minstret_q <= minstret_q + word_t'(1);
      end
      if (load_granted) begin
        mloads_q <= mloads_q + word_t'(1);
      end
      if (store_granted) begin
        mstores_q <= mstores_q + word_t'(1);
      end
    end
  end

endmodule

// ==== core_top.sv ====
// RV32 core top level
// Connects fetch, decode/execute, load/store unit and CSRs, and reports
// a registered core-busy flag

module core_top
  import core_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     fetch_enable_i,
  input  addr_t    boot_addr_i,
  output mem_req_t instr_req_o,
  input  mem_rsp_t instr_rsp_i,
  output mem_req_t data_req_o,
  input  mem_rsp_t data_rsp_i,
  output logic     core_busy_o
);

  logic     instr_valid;
  word_t    instr_rdata;
  logic     instr_taken;
  lsu_cmd_t lsu_cmd;
  logic     lsu_done;
  word_t    lsu_rdata;
  csr_cmd_t csr_cmd;
  word_t    csr_rdata;
  logic     instr_retired;
  logic     if_busy;
  logic     ctrl_busy;
  logic     lsu_busy;
  logic     core_busy_q;

  ////////////////////////////////////////
  // Busy flag
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= if_busy | ctrl_busy | lsu_busy;
    end
  end

  assign core_busy_o = core_busy_q;

  ////////////////////////////////////////
  // Stages
  ////////////////////////////////////////

  // PC of the buffered word has no consumer without branches
  core_if_stage i_if_stage (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_rsp_i    (instr_rsp_i),
    .instr_valid_o  (instr_valid),
    .instr_rdata_o  (instr_rdata),
    .instr_pc_o     (),
    .instr_taken_i  (instr_taken),
    .busy_o         (if_busy)
  );

  core_id_ex_stage i_id_ex_stage (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .instr_valid_i   (instr_valid),
    .instr_rdata_i   (instr_rdata),
    .instr_taken_o   (instr_taken),
    .lsu_cmd_o       (lsu_cmd),
    .lsu_done_i      (lsu_done),
    .lsu_rdata_i     (lsu_rdata),
    .csr_cmd_o       (csr_cmd),
    .csr_rdata_i     (csr_rdata),
    .instr_retired_o (instr_retired),
    .busy_o          (ctrl_busy)
  );

  core_load_store_unit i_lsu (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .lsu_cmd_i   (lsu_cmd),
    .data_req_o  (data_req_o),
    .data_rsp_i  (data_rsp_i),
    .lsu_done_o  (lsu_done),
    .lsu_rdata_o (lsu_rdata),
    .busy_o      (lsu_busy)
  );

  core_cs_registers i_cs_registers (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .csr_cmd_i       (csr_cmd),
    .csr_rdata_o     (csr_rdata),
    .instr_retired_i (instr_retired),
    .data_req_i      (data_req_o),
    .data_rsp_i      (data_rsp_i)
  );

endmodule

// ==== tb_core_top.sv ====
// Testbench for the RV32 core top level
// Serves both memory buses with random gnt/rvalid delays, runs a fixed
// program from the boot address and checks the buses with assertions

`include "core_cfg.svh"

module tb_core_top
  import core_pkg::*;
();

  localparam int CYCLES_PER_INSTR = 200;
  localparam int NUM_TESTS        = 6;
  localparam int T_RESET          = 0;
  localparam int T_FETCH          = 1;
  localparam int T_ALU            = 2;
  localparam int T_LS             = 3;
  localparam int T_CSR            = 4;
  localparam int T_BUSY           = 5;
  localparam int MAX_ACCESSES     = 32;

  typedef enum logic [1:0] {BUS_IDLE, BUS_GRANT, BUS_RESPOND} bus_state_e;
  typedef enum logic [2:0] {R_ADD, R_SUB, R_AND, R_OR, R_XOR} rr_kind_e;

  logic     clk_i = 1'b0;
  logic     rst_ni;
  logic     fetch_enable_i;
  addr_t    boot_addr_i;
  mem_req_t instr_req;
  mem_rsp_t instr_rsp = '0;
  mem_req_t data_req;
  mem_rsp_t data_rsp = '0;
  logic     core_busy;

  string test_name [NUM_TESTS] = '{"reset_idle", "fetch_order", "alu_results",
                                   "load_store", "csr_access", "busy_flag"};
  int    errs [NUM_TESTS] = '{default: 0};

  // Program image and memories keyed by the full byte address
  word_t imem [addr_t];
  word_t dmem [addr_t];
  word_t ref_mem [addr_t];
  word_t ref_rf [32];
  word_t ref_mscratch;
  int    n_instr = 0;
  int    prog_len = 0;

  // Expected data bus traffic in program order
  addr_t exp_st_addr [MAX_ACCESSES];
  word_t exp_st_data [MAX_ACCESSES];
  int    st_owner [MAX_ACCESSES];
  addr_t exp_ld_addr [MAX_ACCESSES];
  int    n_st = 0;
  int    n_ld = 0;
  int    test_end_store [NUM_TESTS];

  // Bus model state
  bus_state_e  ibus_state = BUS_IDLE;
  int unsigned ibus_wait = 0;
  addr_t       ibus_addr;
  addr_t       exp_pc = `CORE_BOOT_ADDR;
  bus_state_e  dbus_state = BUS_IDLE;
  int unsigned dbus_wait = 0;
  addr_t       dbus_addr;
  logic        dbus_we;
  int          st_cnt = 0;
  int          ld_cnt = 0;

  always #5 clk_i = ~clk_i;

  core_top i_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req),
    .instr_rsp_i    (instr_rsp),
    .data_req_o     (data_req),
    .data_rsp_i     (data_rsp),
    .core_busy_o    (core_busy)
  );

  ////////////////////////////////////////
  // Memory contents
  ////////////////////////////////////////

  // Custom-0 opcode retires as a no-op in this core
  function automatic word_t instr_fill(addr_t a);
    return {a[31:7] ^ a[24:0], 7'h0B};
  endfunction

  function automatic word_t data_init(addr_t a);
    if (a == 32'h0000_0100) begin
      return 32'h0000_1234;
    end
    return {a[15:0], a[31:16]} ^ 32'hA5A5_A5A5;
  endfunction

  function automatic word_t sext(logic [11:0] imm);
    return {{20{imm[11]}}, imm};
  endfunction

  ////////////////////////////////////////
  // Instruction encoding and reference model
  ////////////////////////////////////////

  function automatic word_t i_format(logic [6:0] opc, logic [2:0] f3, reg_addr_t rd,
                                     reg_addr_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t r_format(logic [6:0] f7, logic [2:0] f3, reg_addr_t rd,
                                     reg_addr_t rs1, reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  task automatic emit(word_t instr);
    imem[addr_t'(`CORE_BOOT_ADDR) + addr_t'(4 * n_instr)] = instr;
    n_instr++;
  endtask

  // x0 stays zero
  task automatic set_ref(reg_addr_t rd, word_t v);
    if (rd != '0) begin
      ref_rf[rd] = v;
    end
  endtask

  task automatic addi(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
    emit(i_format(7'h13, 3'b000, rd, rs1, imm));
    set_ref(rd, ref_rf[rs1] + sext(imm));
  endtask

  task automatic lui(reg_addr_t rd, logic [19:0] imm);
    emit({imm, rd, 7'h37});
    set_ref(rd, {imm, 12'h000});
  endtask

  task automatic alu_rr(rr_kind_e kind, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    logic [6:0] f7;
    logic [2:0] f3;
    word_t      a;
    word_t      b;
    word_t      v;
    a  = ref_rf[rs1];
    b  = ref_rf[rs2];
    f7 = 7'h00;
    case (kind)
      R_SUB: begin
        f3 = 3'b000;
        f7 = 7'h20;
        v  = a - b;
      end
      R_AND: begin
        f3 = 3'b111;
        v  = a & b;
      end
      R_OR: begin
        f3 = 3'b110;
        v  = a | b;
      end
      R_XOR: begin
        f3 = 3'b100;
        v  = a ^ b;
      end
      default: begin
        f3 = 3'b000;
        v  = a + b;
      end
    endcase
    emit(r_format(f7, f3, rd, rs1, rs2));
    set_ref(rd, v);
  endtask

  task automatic lw(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
    addr_t a;
    a = ref_rf[rs1] + sext(imm);
    exp_ld_addr[n_ld] = a;
    n_ld++;
    emit(i_format(7'h03, 3'b010, rd, rs1, imm));
    set_ref(rd, ref_mem.exists(a) ? ref_mem[a] : data_init(a));
  endtask

  task automatic sw(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm, int owner);
    addr_t a;
    a = ref_rf[rs1] + sext(imm);
    exp_st_addr[n_st] = a;
    exp_st_data[n_st] = ref_rf[rs2];
    st_owner[n_st]    = owner;
    ref_mem[a]        = ref_rf[rs2];
    n_st++;
    emit({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23});
  endtask

  // Counters read the events of all earlier instructions
  task automatic csr_rmw(reg_addr_t rd, csr_addr_t csr, reg_addr_t rs1, logic set);
    word_t old;
    case (csr)
      `CORE_CSR_MSCRATCH: old = ref_mscratch;
      `CORE_CSR_MINSTRET: old = word_t'(n_instr);
      `CORE_CSR_MLOADS:   old = word_t'(n_ld);
      `CORE_CSR_MSTORES:  old = word_t'(n_st);
      default:            old = '0;
    endcase
    if (csr == `CORE_CSR_MSCRATCH) begin
      ref_mscratch = set ? (ref_mscratch | ref_rf[rs1]) : ref_rf[rs1];
    end
    emit(i_format(7'h73, set ? 3'b010 : 3'b001, rd, rs1, csr));
    set_ref(rd, old);
  endtask

  task automatic build_program();
    ref_rf       = '{default: '0};
    ref_mscratch = '0;
    // ALU results stored from 0x200
    addi(5'd10, 5'd0, 12'h200);
    addi(5'd1, 5'd0, 12'h123);
    addi(5'd2, 5'd0, 12'hFFB);
    lui(5'd3, 20'hABCDE);
    alu_rr(R_ADD, 5'd4, 5'd1, 5'd3);
    alu_rr(R_SUB, 5'd5, 5'd1, 5'd2);
    alu_rr(R_AND, 5'd6, 5'd3, 5'd2);
    alu_rr(R_OR, 5'd7, 5'd1, 5'd3);
    alu_rr(R_XOR, 5'd8, 5'd2, 5'd3);
    addi(5'd0, 5'd1, 12'h007);
    for (int r = 1; r <= 8; r++) begin
      sw(reg_addr_t'(r), 5'd10, 12'(4 * (r - 1)), T_ALU);
    end
    sw(5'd0, 5'd10, 12'h020, T_ALU);
    test_end_store[T_ALU] = n_st;
    // Load, increment, store back next to it
    addi(5'd11, 5'd0, 12'h100);
    lw(5'd12, 5'd11, 12'h000);
    addi(5'd12, 5'd12, 12'h001);
    sw(5'd12, 5'd11, 12'h004, T_LS);
    test_end_store[T_LS] = n_st;
    // CSR results stored from 0x300
    addi(5'd13, 5'd0, 12'h300);
    lui(5'd14, 20'h5A5A5);
    addi(5'd14, 5'd14, 12'h0F0);
    csr_rmw(5'd15, `CORE_CSR_MSCRATCH, 5'd14, 1'b0);
    csr_rmw(5'd16, `CORE_CSR_MSCRATCH, 5'd1, 1'b1);
    csr_rmw(5'd17, `CORE_CSR_MSCRATCH, 5'd0, 1'b1);
    csr_rmw(5'd18, `CORE_CSR_MINSTRET, 5'd0, 1'b1);
    csr_rmw(5'd19, `CORE_CSR_MLOADS, 5'd0, 1'b1);
    csr_rmw(5'd20, `CORE_CSR_MSTORES, 5'd0, 1'b1);
    for (int r = 15; r <= 20; r++) begin
      sw(reg_addr_t'(r), 5'd13, 12'(4 * (r - 15)), T_CSR);
    end
    test_end_store[T_CSR] = n_st;
    prog_len = n_instr;
  endtask

  ////////////////////////////////////////
  // Bus models
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      instr_rsp.rvalid <= 1'b0;
      case (ibus_state)
        BUS_IDLE: begin
          if (instr_req.req) begin
            ibus_wait  <= $urandom_range(3, 0);
            ibus_state <= BUS_GRANT;
          end
        end
        BUS_GRANT: begin
          if (instr_rsp.gnt) begin
            instr_rsp.gnt <= 1'b0;
            ibus_addr     <= instr_req.addr;
            exp_pc        <= exp_pc + 32'd4;
            ibus_wait     <= $urandom_range(3, 0);
            ibus_state    <= BUS_RESPOND;
          end else if (ibus_wait == 0) begin
            instr_rsp.gnt <= 1'b1;
          end else begin
            ibus_wait <= ibus_wait - 1;
          end
        end
        default: begin
          if (ibus_wait == 0) begin
            instr_rsp.rvalid <= 1'b1;
            instr_rsp.rdata  <= imem.exists(ibus_addr) ? imem[ibus_addr] : instr_fill(ibus_addr);
            ibus_state       <= BUS_IDLE;
          end else begin
            ibus_wait <= ibus_wait - 1;
          end
        end
      endcase
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni) begin
      data_rsp.rvalid <= 1'b0;
      case (dbus_state)
        BUS_IDLE: begin
          if (data_req.req) begin
            dbus_wait  <= $urandom_range(3, 0);
            dbus_state <= BUS_GRANT;
          end
        end
        BUS_GRANT: begin
          if (data_rsp.gnt) begin
            data_rsp.gnt <= 1'b0;
            dbus_addr    <= data_req.addr;
            dbus_we      <= data_req.we;
            if (data_req.we) begin
              dmem[data_req.addr] = data_req.wdata;
              st_cnt <= st_cnt + 1;
            end else begin
              ld_cnt <= ld_cnt + 1;
            end
            dbus_wait  <= $urandom_range(3, 0);
            dbus_state <= BUS_RESPOND;
          end else if (dbus_wait == 0) begin
            data_rsp.gnt <= 1'b1;
          end else begin
            dbus_wait <= dbus_wait - 1;
          end
        end
        default: begin
          if (dbus_wait == 0) begin
            data_rsp.rvalid <= 1'b1;
            if (dbus_we) begin
              data_rsp.rdata <= '0;
            end else begin
              data_rsp.rdata <= dmem.exists(dbus_addr) ? dmem[dbus_addr] : data_init(dbus_addr);
            end
            dbus_state <= BUS_IDLE;
          end else begin
            dbus_wait <= dbus_wait - 1;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Quiet through reset and until the core is enabled
  a_reset_idle: assert property (@(posedge clk_i)
    !fetch_enable_i |-> !instr_req.req && !data_req.req && !core_busy)
    else begin
      errs[T_RESET] = errs[T_RESET] + 1;
      $display("Error reset_idle: expected req/req/busy 000, actual %b%b%b",
               $sampled(instr_req.req), $sampled(data_req.req), $sampled(core_busy));
    end

  a_fetch_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req.req && instr_rsp.gnt |->
      instr_req.addr == exp_pc && !instr_req.we && instr_req.be == 4'hF)
    else begin
      errs[T_FETCH] = errs[T_FETCH] + 1;
      $display("Error fetch_order: expected address %h we 0 be f, actual %h we %b be %h",
               $sampled(exp_pc), $sampled(instr_req.addr), $sampled(instr_req.we),
               $sampled(instr_req.be));
    end

  a_fetch_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req.req && !instr_rsp.gnt |=> instr_req.req && $stable(instr_req))
    else begin
      errs[T_FETCH] = errs[T_FETCH] + 1;
      $display("fetch_order: instruction request changed before its grant");
    end

  a_store_value: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req.req && data_rsp.gnt && data_req.we |->
      st_cnt < n_st && data_req.addr == exp_st_addr[st_cnt] &&
      data_req.wdata == exp_st_data[st_cnt] && data_req.be == 4'hF)
    else begin
      if ($sampled(st_cnt) >= n_st) begin
        errs[T_LS] = errs[T_LS] + 1;
        $display("load_store: store beyond the end of the program");
      end else begin
        errs[st_owner[$sampled(st_cnt)]] = errs[st_owner[$sampled(st_cnt)]] + 1;
        $display("Error %s: store %0d expected %h at %h be f, actual %h at %h be %h",
                 test_name[st_owner[$sampled(st_cnt)]], $sampled(st_cnt),
                 exp_st_data[$sampled(st_cnt)], exp_st_addr[$sampled(st_cnt)],
                 $sampled(data_req.wdata), $sampled(data_req.addr), $sampled(data_req.be));
      end
    end

  a_load_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req.req && data_rsp.gnt && !data_req.we |->
      ld_cnt < n_ld && data_req.addr == exp_ld_addr[ld_cnt] && data_req.be == 4'hF)
    else begin
      errs[T_LS] = errs[T_LS] + 1;
      if ($sampled(ld_cnt) >= n_ld) begin
        $display("load_store: load beyond the end of the program");
      end else begin
        $display("Error load_store: load %0d expected address %h be f, actual %h be %h",
                 $sampled(ld_cnt), exp_ld_addr[$sampled(ld_cnt)], $sampled(data_req.addr),
                 $sampled(data_req.be));
      end
    end

  a_data_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req.req && !data_rsp.gnt |=> data_req.req && $stable(data_req))
    else begin
      errs[T_LS] = errs[T_LS] + 1;
      $display("load_store: data request changed before its grant");
    end

  a_busy_run: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_enable_i |=> core_busy)
    else begin
      errs[T_BUSY] = errs[T_BUSY] + 1;
      $display("Error busy_flag: expected core_busy_o 1 while running, actual 0");
    end

  a_busy_data: assert property (@(posedge clk_i) disable iff (!rst_ni)
    data_req.req |=> core_busy)
    else begin
      errs[T_BUSY] = errs[T_BUSY] + 1;
      $display("Error busy_flag: expected core_busy_o 1 after a data request, actual 0");
    end

  ////////////////////////////////////////
  // Sequence and report
  ////////////////////////////////////////

  task automatic report_test(int t);
    if (errs[t] == 0) begin
      $display("test %s: ok", test_name[t]);
    end else begin
      $display("test %s: %0d error(s)", test_name[t], errs[t]);
    end
  endtask

  initial begin
    int n_bad;
    int n_err;
    void'($urandom(32'h659e7ada));
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b0;
    boot_addr_i    = `CORE_BOOT_ADDR;
    build_program();
    repeat (2) @(posedge clk_i);
    rst_ni <= 1'b1;
    repeat (3) @(posedge clk_i);
    fetch_enable_i <= 1'b1;
    @(posedge clk_i);
    report_test(T_RESET);
    // Each test ends once the check of its last store has run
    for (int t = T_ALU; t <= T_CSR; t++) begin
      while (st_cnt < test_end_store[t]) begin
        @(posedge clk_i);
      end
      @(posedge clk_i);
      report_test(t);
    end
    while (dbus_state != BUS_IDLE || data_req.req) begin
      @(posedge clk_i);
    end
    // Tail of no-op fetches after the final store
    repeat (4) @(posedge clk_i);
    report_test(T_FETCH);
    report_test(T_BUSY);
    n_bad = 0;
    n_err = 0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      if (errs[t] != 0) begin
        n_bad++;
      end
      n_err += errs[t];
    end
    $display("Summary: %0d tests, %0d ok, %0d with errors, %0d errors in all",
             NUM_TESTS, NUM_TESTS - n_bad, n_bad, n_err);
    if (n_err == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    wait (prog_len != 0);
    repeat (CYCLES_PER_INSTR * prog_len) @(posedge clk_i);
    $display("Watchdog: program of %0d instructions did not finish in %0d cycles",
             prog_len, CYCLES_PER_INSTR * prog_len);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+.
core_pkg.sv
core_if_stage.sv
core_id_ex_stage.sv
core_load_store_unit.sv
core_cs_registers.sv
core_top.sv
tb_core_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f \
  --top-module tb_core_top --Mdir obj_dir -o sim_core

./obj_dir/sim_core | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
grep -q "TESTS PASSED" sim.log
